// ==== hw/turf_hsk_pkg.sv ====
package turf_hsk_pkg;

    //////////////////////////////
    // Register bus geometry
    //////////////////////////////

    localparam int ADDR_W = 14;
    localparam int DATA_W = 32;

    // Number of TURFIOs hanging off the TURF
    localparam int NUM_TIO = 4;

    // Address bit that splits ID/control space (0) from bridge space (1)
    localparam int SPACE_BIT = 13;

    //////////////////////////////
    // Register offsets
    //////////////////////////////

    // ID/control space
    localparam logic [ADDR_W-1:0] REG_IDENT     = 14'h0000;
    localparam logic [ADDR_W-1:0] REG_DATEVER   = 14'h0004;
    localparam logic [ADDR_W-1:0] REG_GPO_CTRL  = 14'h0008;
    localparam logic [ADDR_W-1:0] REG_STATUS    = 14'h000C;
    localparam logic [ADDR_W-1:0] REG_TIO_RESET = 14'h0010;

    // Bridge space
    localparam logic [ADDR_W-1:0] REG_BRIDGE_TYPE    = 14'h0000;
    localparam logic [ADDR_W-1:0] REG_BRIDGE_INVALID = 14'h0004;

    // TOUT source select, codes 4 to 7 select nothing
    typedef enum logic [2:0] {
        GPO_SYNC = 3'd0,
        GPO_RUN  = 3'd1,
        GPO_TRIG = 3'd2,
        GPO_PPS  = 3'd3
    } gpo_sel_t;

    // Register bridge type, one per TURFIO
    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_type_t;

endpackage

// ==== hw/wb_if.sv ====
interface wb_if;
    import turf_hsk_pkg::*;

    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

// ==== hw/turf_intercon.sv ====
module turf_intercon (
    input  logic                            ps_clk,
    input  logic                            rst_n_i,

    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [turf_hsk_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [turf_hsk_pkg::DATA_W-1:0] wb_dat_i,
    output logic [turf_hsk_pkg::DATA_W-1:0] wb_dat_o,
    output logic                            wb_ack_o,

    wb_if.master                            id_bus,
    wb_if.master                            bridge_bus
);
    import turf_hsk_pkg::*;

    logic                  space_sel;
    logic                  space_q;
    logic [ADDR_W-1:0]     local_adr;

    assign space_sel = wb_adr_i[SPACE_BIT];
    // Strip the space bit, slaves only see their own offsets
    assign local_adr = {{(ADDR_W-SPACE_BIT){1'b0}}, wb_adr_i[SPACE_BIT-1:0]};

    // Request fan-out
    assign id_bus.cyc   = wb_cyc_i;
    assign id_bus.stb   = wb_stb_i & ~space_sel;
    assign id_bus.we    = wb_we_i;
    assign id_bus.adr   = local_adr;
    assign id_bus.dat_w = wb_dat_i;

    assign bridge_bus.cyc   = wb_cyc_i;
    assign bridge_bus.stb   = wb_stb_i & space_sel;
    assign bridge_bus.we    = wb_we_i;
    assign bridge_bus.adr   = local_adr;
    assign bridge_bus.dat_w = wb_dat_i;

    // Remember which space was addressed when the slaves sampled stb,
    // so the return mux lines up with the ack cycle
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            space_q <= 1'b0;
        end else if (wb_cyc_i && wb_stb_i) begin
            space_q <= space_sel;
        end
    end

    ////////////////////////////////
    // Response return
    ////////////////////////////////

    assign wb_ack_o = space_q ? bridge_bus.ack : id_bus.ack;

    // Data bus reads as zero outside the ack cycle
    always_comb begin
        wb_dat_o = '0;
        if (wb_ack_o) begin
            wb_dat_o = space_q ? bridge_bus.dat_r : id_bus.dat_r;
        end
    end

endmodule

// ==== hw/turf_id_ctrl.sv ====
module turf_id_ctrl #(
    parameter logic [turf_hsk_pkg::DATA_W-1:0] IDENT       = "TURF",
    parameter logic [turf_hsk_pkg::DATA_W-1:0] DATEVERSION = '0
) (
    input  logic                             ps_clk,
    input  logic                             rst_n_i,

    wb_if.slave                              bus,

    input  logic                             uart_irq_b_i,
    input  logic                             hsk_irq_i,
    input  logic                             hsk_complete_i,
    input  logic [1:0]                       gps_timepulse_i,

    output logic                             gpo_en_o,
    output turf_hsk_pkg::gpo_sel_t           gpo_sel_o,
    output logic [turf_hsk_pkg::NUM_TIO-1:0] tio_resetb_o
);
    import turf_hsk_pkg::*;

    logic               wr_en;
    logic               gpo_en_q;
    gpo_sel_t           gpo_sel_q;
    logic [NUM_TIO-1:0] tio_reset_q;
    logic [4:0]         status_meta_q;
    logic [4:0]         status_q;
    logic [4:0]         status_raw;

    // Same bit packing as the low EMIO bits on the processor side
    assign status_raw = {gps_timepulse_i, hsk_complete_i, hsk_irq_i, uart_irq_b_i};

    // Write lands on the edge that raises ack
    assign wr_en = bus.cyc & bus.stb & ~bus.ack & bus.we;

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.cyc & bus.stb & ~bus.ack;
        end
    end

    ////////////////////////////////
    // Control registers
    ////////////////////////////////

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpo_en_q    <= 1'b0;
            gpo_sel_q   <= GPO_SYNC;
            tio_reset_q <= '0;
        end else if (wr_en) begin
            if (bus.adr == REG_GPO_CTRL) begin
                gpo_en_q  <= bus.dat_w[3];
                gpo_sel_q <= gpo_sel_t'(bus.dat_w[2:0]);
            end
            if (bus.adr == REG_TIO_RESET) begin
                tio_reset_q <= bus.dat_w[NUM_TIO-1:0];
            end
        end
    end

    // Status lines are asynchronous to ps_clk
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            status_meta_q <= '0;
            status_q      <= '0;
        end else begin
            status_meta_q <= status_raw;
            status_q      <= status_meta_q;
        end
    end

    assign gpo_en_o     = gpo_en_q;
    assign gpo_sel_o    = gpo_sel_q;
    // Zero holds the TURFIO in reset
    assign tio_resetb_o = tio_reset_q;

    ////////////////////////////////
    // Readback
    ////////////////////////////////

    always_comb begin
        bus.dat_r = '0;
        case (bus.adr)
            REG_IDENT:     bus.dat_r = IDENT;
            REG_DATEVER:   bus.dat_r = DATEVERSION;
            REG_GPO_CTRL:  bus.dat_r = DATA_W'({gpo_en_q, gpo_sel_q});
            REG_STATUS:    bus.dat_r = DATA_W'(status_q);
            REG_TIO_RESET: bus.dat_r = DATA_W'(tio_reset_q);
            default:       bus.dat_r = '0;
        endcase
    end

endmodule

// ==== hw/turf_bridge_ctrl.sv ====
module turf_bridge_ctrl (
    input  logic                               ps_clk,
    input  logic                               rst_n_i,

    wb_if.slave                                bus,

    input  logic [turf_hsk_pkg::NUM_TIO-1:0]   aurora_up_i,
    output logic [2*turf_hsk_pkg::NUM_TIO-1:0] bridge_route_o
);
    import turf_hsk_pkg::*;

    logic                              wr_en;
    bridge_type_t [NUM_TIO-1:0]        type_q;
    bridge_type_t [NUM_TIO-1:0]        route_q;
    logic [NUM_TIO-1:0]                valid;
    logic [NUM_TIO-1:0]                invalid_q;
    logic [NUM_TIO-1:0]                invalid_clr;

    assign wr_en = bus.cyc & bus.stb & ~bus.ack & bus.we;

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.cyc & bus.stb & ~bus.ack;
        end
    end

    // Bridge type per TURFIO, 2 bits each
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_TIO; i++) begin
                type_q[i] <= BRIDGE_NONE;
            end
        end else if (wr_en && bus.adr == REG_BRIDGE_TYPE) begin
            for (int i = 0; i < NUM_TIO; i++) begin
                type_q[i] <= bridge_type_t'(bus.dat_w[2*i +: 2]);
            end
        end
    end

    ////////////////////////////////
    // Validity vs. link state
    ////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_TIO; i++) begin
            case (type_q[i])
                BRIDGE_NONE:   valid[i] = 1'b1;
                BRIDGE_AURORA: valid[i] = aurora_up_i[i];
                default:       valid[i] = 1'b0;
            endcase
        end
    end

    // Write-one-to-clear, the clear wins for one cycle
    assign invalid_clr = (wr_en && bus.adr == REG_BRIDGE_INVALID) ?
                         bus.dat_w[NUM_TIO-1:0] : '0;

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            invalid_q <= '0;
            for (int i = 0; i < NUM_TIO; i++) begin
                route_q[i] <= BRIDGE_NONE;
            end
        end else begin
            invalid_q <= ~invalid_clr & (invalid_q | ~valid);
            for (int i = 0; i < NUM_TIO; i++) begin
                route_q[i] <= valid[i] ? type_q[i] : BRIDGE_NONE;
            end
        end
    end

    assign bridge_route_o = route_q;

    always_comb begin
        case (bus.adr)
            REG_BRIDGE_TYPE:    bus.dat_r = DATA_W'(type_q);
            REG_BRIDGE_INVALID: bus.dat_r = DATA_W'(invalid_q);
            default:            bus.dat_r = '0;
        endcase
    end

endmodule

// ==== hw/turf_gpo_mux.sv ====
module turf_gpo_mux (
    input  logic                             ps_clk,
    input  logic                             rst_n_i,

    input  logic                             gpo_en_i,
    input  turf_hsk_pkg::gpo_sel_t           gpo_sel_i,
    input  logic [turf_hsk_pkg::NUM_TIO-1:0] gpo_ce_i,
    input  logic [turf_hsk_pkg::NUM_TIO-1:0] gpo_d_i,

    output logic                             tout_o
);
    import turf_hsk_pkg::*;

    logic       src_ok;
    logic [1:0] src_idx;
    logic       tout_q;

    // Map the select code onto a source slot
    always_comb begin
        src_ok  = gpo_en_i;
        src_idx = 2'd0;
        case (gpo_sel_i)
            GPO_SYNC: src_idx = 2'd0;
            GPO_RUN:  src_idx = 2'd1;
            GPO_TRIG: src_idx = 2'd2;
            GPO_PPS:  src_idx = 2'd3;
            default:  src_ok  = 1'b0;
        endcase
    end

    // Output only moves on the selected source's clock enable
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tout_q <= 1'b0;
        end else if (!src_ok) begin
            tout_q <= 1'b0;
        end else if (gpo_ce_i[src_idx]) begin
            tout_q <= gpo_d_i[src_idx];
        end
    end

    assign tout_o = tout_q;

endmodule

// ==== hw/baud_tick_gen.sv ====
module baud_tick_gen #(
    parameter int          FRAC_W = 10,
    parameter int unsigned ADD    = 82
) (
    input  logic ps_clk,
    input  logic rst_n_i,
    output logic tick_o
);

    logic [FRAC_W-1:0] acc_q;
    logic [FRAC_W:0]   sum;
    logic              tick_q;

    // Carry out of the phase accumulator is the tick
    assign sum = {1'b0, acc_q} + (FRAC_W+1)'(ADD);

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            acc_q  <= sum[FRAC_W-1:0];
            tick_q <= sum[FRAC_W];
        end
    end

    assign tick_o = tick_q;

endmodule

// ==== hw/turf_hsk_top.sv ====
module turf_hsk_top #(
    parameter logic [31:0] IDENT         = "TURF",
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd7,
    parameter logic [7:0]  VER_REV       = 8'd29,
    parameter logic [15:0] FIRMWARE_DATE = 16'h0000,
    parameter logic        REVISION_B    = 1'b0,
    parameter int unsigned HSK_ADD       = 82,
    parameter int unsigned GPS_ADD       = 25
) (
    input  logic                               ps_clk,
    input  logic                               rst_n_i,

    // Register bus from the processor
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  logic [turf_hsk_pkg::ADDR_W-1:0]    wb_adr_i,
    input  logic [turf_hsk_pkg::DATA_W-1:0]    wb_dat_i,
    output logic [turf_hsk_pkg::DATA_W-1:0]    wb_dat_o,
    output logic                               wb_ack_o,

    // TOUT sources
    input  logic                               gpo_sync_ce_i,
    input  logic                               gpo_sync_d_i,
    input  logic                               gpo_run_ce_i,
    input  logic                               gpo_run_d_i,
    input  logic                               gpo_trig_ce_i,
    input  logic                               gpo_trig_d_i,
    input  logic                               gpo_pps_ce_i,
    input  logic                               gpo_pps_d_i,

    input  logic [turf_hsk_pkg::NUM_TIO-1:0]   aurora_up_i,

    input  logic                               uart_irq_b_i,
    input  logic                               hsk_irq_i,
    input  logic                               hsk_complete_i,
    input  logic [1:0]                         gps_timepulse_i,

    output logic                               tout_o,
    output logic [turf_hsk_pkg::NUM_TIO-1:0]   tio_resetb_o,
    output logic [2*turf_hsk_pkg::NUM_TIO-1:0] bridge_route_o,
    output logic                               hsk_16x_o,
    output logic                               gps_16x_o
);
    import turf_hsk_pkg::*;

    // Top bit flags a rev B board, then date and version
    localparam logic [31:0] DATEVERSION =
        {REVISION_B, FIRMWARE_DATE[14:0], VER_MAJOR, VER_MINOR, VER_REV};

    logic     gpo_en;
    gpo_sel_t gpo_sel;

    wb_if id_bus ();
    wb_if bridge_bus ();

    //////////////////////////////
    // Register spaces
    //////////////////////////////

    turf_intercon u_intercon (
        .ps_clk     (ps_clk),
        .rst_n_i    (rst_n_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .id_bus     (id_bus),
        .bridge_bus (bridge_bus)
    );

    turf_id_ctrl #(
        .IDENT       (IDENT),
        .DATEVERSION (DATEVERSION)
    ) u_id_ctrl (
        .ps_clk          (ps_clk),
        .rst_n_i         (rst_n_i),
        .bus             (id_bus),
        .uart_irq_b_i    (uart_irq_b_i),
        .hsk_irq_i       (hsk_irq_i),
        .hsk_complete_i  (hsk_complete_i),
        .gps_timepulse_i (gps_timepulse_i),
        .gpo_en_o        (gpo_en),
        .gpo_sel_o       (gpo_sel),
        .tio_resetb_o    (tio_resetb_o)
    );

    turf_bridge_ctrl u_bridge_ctrl (
        .ps_clk         (ps_clk),
        .rst_n_i        (rst_n_i),
        .bus            (bridge_bus),
        .aurora_up_i    (aurora_up_i),
        .bridge_route_o (bridge_route_o)
    );

    //////////////////////////////
    // TOUT and serial debug ticks
    //////////////////////////////

    // Vectors follow gpo_sel_t order, sync in bit 0
    turf_gpo_mux u_gpo_mux (
        .ps_clk    (ps_clk),
        .rst_n_i   (rst_n_i),
        .gpo_en_i  (gpo_en),
        .gpo_sel_i (gpo_sel),
        .gpo_ce_i  ({gpo_pps_ce_i, gpo_trig_ce_i, gpo_run_ce_i, gpo_sync_ce_i}),
        .gpo_d_i   ({gpo_pps_d_i, gpo_trig_d_i, gpo_run_d_i, gpo_sync_d_i}),
        .tout_o    (tout_o)
    );

    // 8 MHz from 100 MHz, 82/1024 is within 0.1%
    baud_tick_gen #(
        .FRAC_W (10),
        .ADD    (HSK_ADD)
    ) u_hsk_baud (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (hsk_16x_o)
    );

    // 16x of 38400 baud for the GPS port
    baud_tick_gen #(
        .FRAC_W (12),
        .ADD    (GPS_ADD)
    ) u_gps_baud (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (gps_16x_o)
    );

endmodule

// ==== tb/turf_hsk_properties.sv ====
module turf_hsk_properties (
    input logic                               ps_clk,
    input logic                               rst_n_i,

    input logic                               wb_cyc_i,
    input logic                               wb_stb_i,
    input logic                               wb_we_i,
    input logic [turf_hsk_pkg::ADDR_W-1:0]    wb_adr_i,
    input logic [turf_hsk_pkg::DATA_W-1:0]    wb_dat_i,
    input logic                               wb_ack_o,

    input logic                               gpo_sync_ce_i,
    input logic                               gpo_sync_d_i,
    input logic                               gpo_run_ce_i,
    input logic                               gpo_run_d_i,
    input logic                               gpo_trig_ce_i,
    input logic                               gpo_trig_d_i,
    input logic                               gpo_pps_ce_i,
    input logic                               gpo_pps_d_i,
    input logic                               gpo_en_i,
    input logic [2:0]                         gpo_sel_i,
    input logic                               tout_o,

    input logic [turf_hsk_pkg::NUM_TIO-1:0]   aurora_up_i,
    input logic [2*turf_hsk_pkg::NUM_TIO-1:0] bridge_route_o
);
    import turf_hsk_pkg::*;

    int unsigned            fail_count = 0;

    logic                   req;
    logic [NUM_TIO-1:0]     ce_vec;
    logic [NUM_TIO-1:0]     d_vec;
    logic                   src_ok;
    logic                   sel_ce;
    logic                   sel_d;
    logic [2*NUM_TIO-1:0]   type_q;
    logic [2*NUM_TIO-1:0]   exp_route;

    // New request that is not yet acknowledged
    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    assign ce_vec = {gpo_pps_ce_i, gpo_trig_ce_i, gpo_run_ce_i, gpo_sync_ce_i};
    assign d_vec  = {gpo_pps_d_i, gpo_trig_d_i, gpo_run_d_i, gpo_sync_d_i};
    assign src_ok = gpo_en_i & ~gpo_sel_i[2];
    assign sel_ce = src_ok & ce_vec[gpo_sel_i[1:0]];
    assign sel_d  = d_vec[gpo_sel_i[1:0]];

    // Shadow of the bridge type register from accepted bus writes
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            type_q <= '0;
        end else if (req && wb_we_i && wb_adr_i[SPACE_BIT] &&
                     wb_adr_i[SPACE_BIT-1:0] == REG_BRIDGE_TYPE[SPACE_BIT-1:0]) begin
            type_q <= wb_dat_i[2*NUM_TIO-1:0];
        end
    end

    // Only an Aurora type with its link up is routed
    always_comb begin
        for (int i = 0; i < NUM_TIO; i++) begin
            exp_route[2*i +: 2] = (type_q[2*i +: 2] == BRIDGE_AURORA && aurora_up_i[i]) ?
                                  BRIDGE_AURORA : BRIDGE_NONE;
        end
    end

    //////////////////////////////
    // Bus handshake
    //////////////////////////////

    assert property (@(posedge ps_clk) disable iff (!rst_n_i) $past(req) |-> wb_ack_o)
        else begin
            fail_count++;
            $error("No ack one cycle after stb");
        end

    assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
        else begin
            fail_count++;
            $error("Ack without a request");
        end

    assert property (@(posedge ps_clk) disable iff (!rst_n_i) $past(wb_ack_o) |-> !wb_ack_o)
        else begin
            fail_count++;
            $error("Ack held longer than one cycle");
        end

    //////////////////////////////
    // TOUT and bridge route
    //////////////////////////////

    assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        $past(sel_ce) |-> tout_o == $past(sel_d))
        else begin
            fail_count++;
            $error("TOUT did not take the selected source");
        end

    assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        $past(src_ok && !sel_ce) |-> tout_o == $past(tout_o))
        else begin
            fail_count++;
            $error("TOUT changed without a clock enable");
        end

    assert property (@(posedge ps_clk) disable iff (!rst_n_i) $past(!src_ok) |-> !tout_o)
        else begin
            fail_count++;
            $error("TOUT is not cleared with no source");
        end

    assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        bridge_route_o == $past(exp_route))
        else begin
            fail_count++;
            $error("Bridge route breaks the validity rule");
        end

endmodule

bind turf_hsk_top turf_hsk_properties i_properties (
    .gpo_en_i  (gpo_en),
    .gpo_sel_i (gpo_sel),
    .*
);

// ==== tb/tb_turf_hsk.sv ====
module tb_turf_hsk;
    import turf_hsk_pkg::*;

    localparam logic [31:0] T_IDENT      = 32'h5455_5246;
    localparam logic [3:0]  T_VER_MAJOR  = 4'd1;
    localparam logic [3:0]  T_VER_MINOR  = 4'd3;
    localparam logic [7:0]  T_VER_REV    = 8'h2A;
    localparam logic [15:0] T_DATE       = 16'h1A2B;
    localparam logic        T_REVISION_B = 1'b1;
    // Rev B flag on top of date 0x1A2B, then version 1.3.42
    localparam logic [31:0] T_DATEVER    = 32'h9A2B_132A;
    // GPS tick window of 4096 cycles plus the bus tests and some margin
    localparam int          TIMEOUT_CYCLES = 6000;
    localparam logic [ADDR_W-1:0] BRIDGE_BASE = 14'h2000;

    logic                 ps_clk = 1'b0;
    logic                 rst_n_i;
    logic                 wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [ADDR_W-1:0]    wb_adr_i;
    logic [DATA_W-1:0]    wb_dat_i, wb_dat_o;
    logic                 gpo_sync_ce_i, gpo_sync_d_i, gpo_run_ce_i, gpo_run_d_i;
    logic                 gpo_trig_ce_i, gpo_trig_d_i, gpo_pps_ce_i, gpo_pps_d_i;
    logic [NUM_TIO-1:0]   aurora_up_i, tio_resetb_o;
    logic                 uart_irq_b_i, hsk_irq_i, hsk_complete_i;
    logic [1:0]           gps_timepulse_i;
    logic                 tout_o, hsk_16x_o, gps_16x_o;
    logic [2*NUM_TIO-1:0] bridge_route_o;

    integer      seed = 1574;
    logic [31:0] rnd;
    int          cycles = 0;
    int          edges = 0;
    int          hsk_cnt = 0;
    int          gps_cnt = 0;

    turf_hsk_top #(
        .IDENT (T_IDENT), .VER_MAJOR (T_VER_MAJOR), .VER_MINOR (T_VER_MINOR),
        .VER_REV (T_VER_REV), .FIRMWARE_DATE (T_DATE), .REVISION_B (T_REVISION_B),
        .HSK_ADD (82), .GPS_ADD (25)
    ) i_turf_hsk_top (.*);

    always #2 ps_clk = ~ps_clk;

    // Edge count since reset release and the run limit
    always @(posedge ps_clk) begin
        cycles = cycles + 1;
        if (rst_n_i) edges = edges + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("TEST FAILED");
            $fatal(1, "Timeout, the tests did not finish in %0d cycles", cycles);
        end
    end

    // Tick outputs sampled half a cycle after the edge
    always @(negedge ps_clk) begin
        if (edges >= 1 && edges <= 1024) hsk_cnt = hsk_cnt + int'(hsk_16x_o);
        if (edges >= 1 && edges <= 4096) gps_cnt = gps_cnt + int'(gps_16x_o);
        if (i_turf_hsk_top.i_properties.fail_count != 0) begin
            $display("TEST FAILED");
            $fatal(1, "A handshake, TOUT or route property failed");
        end
    end

    task automatic next_cycle();
        @(posedge ps_clk);
        #1;
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Check %s failed", name);
        end
    endtask

    task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
                              input logic [DATA_W-1:0] dat, output logic [DATA_W-1:0] rd);
        next_cycle();
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        do begin
            next_cycle();
        end while (!wb_ack_o);
        rd       = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
        logic [DATA_W-1:0] unused_rd;
        bus_access(1'b1, adr, dat, unused_rd);
    endtask

    task automatic read_check(input string name, input logic [ADDR_W-1:0] adr,
                              input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] data;
        bus_access(1'b0, adr, '0, data);
        expect_eq(name, exp, data);
    endtask

    task automatic drive_strobes(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            {gpo_pps_ce_i, gpo_trig_ce_i, gpo_run_ce_i, gpo_sync_ce_i} = r[3:0];
            {gpo_pps_d_i, gpo_trig_d_i, gpo_run_d_i, gpo_sync_d_i} = r[7:4];
            next_cycle();
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        {wb_cyc_i, wb_stb_i, wb_we_i, wb_adr_i, wb_dat_i} = '0;
        {gpo_sync_ce_i, gpo_sync_d_i, gpo_run_ce_i, gpo_run_d_i} = '0;
        {gpo_trig_ce_i, gpo_trig_d_i, gpo_pps_ce_i, gpo_pps_d_i} = '0;
        {aurora_up_i, uart_irq_b_i, hsk_irq_i, hsk_complete_i, gps_timepulse_i} = '0;
        repeat (3) @(posedge ps_clk);
        #1;
        rst_n_i = 1'b1;

        // Identification and unmapped space
        read_check("ident", REG_IDENT, T_IDENT);
        read_check("dateversion", REG_DATEVER, T_DATEVER);
        read_check("unmapped_id", 14'h0020, 32'h0);
        read_check("unmapped_bridge", BRIDGE_BASE | 14'h0010, 32'h0);

        // TURFIO resets and status readback
        expect_eq("tio_reset_default", 32'h0, 32'(tio_resetb_o));
        bus_write(REG_TIO_RESET, 32'hA);
        expect_eq("tio_reset_at_ack", 32'hA, 32'(tio_resetb_o));
        read_check("tio_reset_readback", REG_TIO_RESET, 32'hA);
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            {gps_timepulse_i, hsk_complete_i, hsk_irq_i, uart_irq_b_i} = rnd[4:0];
            repeat (3) next_cycle();
            read_check("status", REG_STATUS, {27'd0, rnd[4:0]});
        end

        // Each TOUT source in turn and then no source
        for (int s = 0; s < 4; s++) begin
            bus_write(REG_GPO_CTRL, 32'(8 + s));
            drive_strobes(24);
        end
        for (int s = 4; s < 8; s++) begin
            bus_write(REG_GPO_CTRL, 32'(8 + s));
            drive_strobes(6);
            expect_eq("tout_no_source", 32'h0, 32'(tout_o));
        end
        bus_write(REG_GPO_CTRL, 32'h1);
        drive_strobes(8);
        expect_eq("tout_disabled", 32'h0, 32'(tout_o));

        // Random bridge types against a changing link state
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            aurora_up_i = rnd[11:8];
            bus_write(BRIDGE_BASE | REG_BRIDGE_TYPE, {24'd0, rnd[7:0]});
            aurora_up_i = rnd[15:12];
            repeat (3) next_cycle();
        end

        ///////////////////////////////
        // Sticky invalid flags
        bus_write(BRIDGE_BASE | REG_BRIDGE_TYPE, 32'h0);
        bus_write(BRIDGE_BASE | REG_BRIDGE_INVALID, 32'hF);
        read_check("invalid_cleared", BRIDGE_BASE | REG_BRIDGE_INVALID, 32'h0);
        aurora_up_i = 4'b0101;
        bus_write(BRIDGE_BASE | REG_BRIDGE_TYPE, 32'h55);
        next_cycle();
        // TURFIO 0 and 2 have their link up and route Aurora
        expect_eq("route_link_down", 32'h11, 32'(bridge_route_o));
        read_check("invalid_link_down", BRIDGE_BASE | REG_BRIDGE_INVALID, 32'hA);
        bus_write(BRIDGE_BASE | REG_BRIDGE_TYPE, 32'hAA);
        next_cycle();
        bus_write(BRIDGE_BASE | REG_BRIDGE_INVALID, 32'hF);
        read_check("invalid_reserved", BRIDGE_BASE | REG_BRIDGE_INVALID, 32'hF);
        aurora_up_i = 4'hF;
        bus_write(BRIDGE_BASE | REG_BRIDGE_TYPE, 32'h55);
        bus_write(BRIDGE_BASE | REG_BRIDGE_INVALID, 32'hF);
        read_check("invalid_all_up", BRIDGE_BASE | REG_BRIDGE_INVALID, 32'h0);
        read_check("bridge_type", BRIDGE_BASE | REG_BRIDGE_TYPE, 32'h55);
        expect_eq("route_all_up", 32'h55, 32'(bridge_route_o));

        // Tick windows of 1024 and 4096 cycles
        while (edges <= 4096) next_cycle();
        expect_eq("hsk_ticks", 32'd82, 32'(hsk_cnt));
        expect_eq("gps_ticks", 32'd25, 32'(gps_cnt));

        if (i_turf_hsk_top.i_properties.fail_count != 0) begin
            $display("TEST FAILED");
            $fatal(1, "A property failed before the end of the run");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
hw/turf_hsk_pkg.sv
hw/wb_if.sv
hw/turf_intercon.sv
hw/turf_id_ctrl.sv
hw/turf_bridge_ctrl.sv
hw/turf_gpo_mux.sv
hw/baud_tick_gen.sv
hw/turf_hsk_top.sv
tb/turf_hsk_properties.sv
tb/tb_turf_hsk.sv

// ==== Makefile ====
# Verilator build for the TURF housekeeping block

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tb_turf_hsk
RTL_TOP   ?= turf_hsk_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
# Let assertion errors reach the testbench so it can report them
SIM_ARGS  ?= +verilator+error+limit+100

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter hw/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
